//--- src/exu_pkg.sv
/* Datapath types for the RV32 execute unit
   A PC_W-wide PC holds address bits 31:1, bit 0 is always zero */
package exu_pkg;

   localparam int XLEN = 32;                          // RV32 only
   localparam int PC_W = 31;                          // Halfword PC, bits 31:1

   typedef enum logic [4:0] {
      ALU_ADD  = 5'd0,
      ALU_SUB  = 5'd1,
      ALU_SLT  = 5'd2,
      ALU_SLTU = 5'd3,
      ALU_AND  = 5'd4,
      ALU_OR   = 5'd5,
      ALU_XOR  = 5'd6,
      ALU_SLL  = 5'd7,
      ALU_SRL  = 5'd8,
      ALU_SRA  = 5'd9,
      ALU_BEQ  = 5'd10,
      ALU_BNE  = 5'd11,
      ALU_BLT  = 5'd12,
      ALU_BGE  = 5'd13,
      ALU_BLTU = 5'd14,
      ALU_BGEU = 5'd15,
      ALU_JAL  = 5'd16
   } alu_op_e;

   typedef struct packed {
      logic    valid;
      alu_op_e op;
      logic    branch;                                // Conditional branch or jal
      logic    pc4;                                   // 4-byte encoding, else compressed
   } alu_pkt_t;

   // One-hot, all zero means the GPR path is used
   typedef struct packed {
      logic r_result;
      logic lsu_m;
      logic x_result;
   } bypass_sel_t;

   typedef struct packed {
      logic        rs1_en;
      logic        rs2_en;
      logic        select_pc;                         // PC to rs1 for jal
      logic        qual_lsu;                          // Load/store at D
      bypass_sel_t rs1_byp;
      bypass_sel_t rs2_byp;
   } dstage_t;

endpackage

//--- src/bp_pkg.sv
/* Branch predictor interface types
   The report fghr width is GHR_W, so module GHR_W must keep this default */
package bp_pkg;

   localparam int GHR_W     = 8;
   localparam int TOFFSET_W = 12;                     // Target offset in halfwords

   typedef struct packed {
      logic                 valid;
      logic                 way;
      logic                 misp;                     // Set at X on a mispredict
      logic                 ataken;                   // Predicted at D, actual after X
      logic                 pc4;
      logic                 boffset;                  // PC bit 1 of the branch
      logic                 pcall;
      logic                 pja;
      logic                 pret;
      logic [1:0]           hist;
      logic [TOFFSET_W-1:0] toffset;
   } predict_pkt_t;

   typedef struct packed {
      logic             valid;
      logic             mp;
      logic             way;
      logic             middle;                       // Branch ends mid fetch word
      logic [1:0]       hist;
      logic [GHR_W-1:0] fghr;
   } br_report_t;

endpackage

//--- src/exu_operand_mux.sv
/* D-stage operand select, purely combinational
   Bypass selects must be one-hot per operand, several set bits OR together */
`timescale 1ns/10ps

module exu_operand_mux (
   input  exu_pkg::dstage_t         i_dstage,
   input  logic [exu_pkg::XLEN-1:0] i_gpr_rs1,
   input  logic [exu_pkg::XLEN-1:0] i_gpr_rs2,
   input  logic [exu_pkg::XLEN-1:0] i_immed,
   input  logic [exu_pkg::PC_W-1:0] i_pc_d,
   input  logic [exu_pkg::XLEN-1:0] i_result_r,
   input  logic [exu_pkg::XLEN-1:0] i_lsu_result_m,
   input  logic [exu_pkg::XLEN-1:0] i_result_x,
   output logic [exu_pkg::XLEN-1:0] o_rs1,
   output logic [exu_pkg::XLEN-1:0] o_rs2,
   output logic [exu_pkg::XLEN-1:0] o_lsu_rs1,
   output logic [exu_pkg::XLEN-1:0] o_lsu_rs2
);

   logic                     rs1_byp_en;
   logic                     rs2_byp_en;
   logic [exu_pkg::XLEN-1:0] rs1_byp_data;
   logic [exu_pkg::XLEN-1:0] rs2_byp_data;
   logic [exu_pkg::XLEN-1:0] lsu_rs1_src;
   logic [exu_pkg::XLEN-1:0] lsu_rs2_src;

   function automatic logic [exu_pkg::XLEN-1:0] byp_data(
      input exu_pkg::bypass_sel_t     sel,
      input logic [exu_pkg::XLEN-1:0] result_r,
      input logic [exu_pkg::XLEN-1:0] result_m,
      input logic [exu_pkg::XLEN-1:0] result_x
   );
      byp_data = ({exu_pkg::XLEN{sel.r_result}} & result_r) |
                 ({exu_pkg::XLEN{sel.lsu_m}}    & result_m) |
                 ({exu_pkg::XLEN{sel.x_result}} & result_x);
   endfunction

   assign rs1_byp_en   = |i_dstage.rs1_byp;
   assign rs2_byp_en   = |i_dstage.rs2_byp;
   assign rs1_byp_data = byp_data(i_dstage.rs1_byp, i_result_r, i_lsu_result_m, i_result_x);
   assign rs2_byp_data = byp_data(i_dstage.rs2_byp, i_result_r, i_lsu_result_m, i_result_x);

   assign o_rs1 = rs1_byp_en         ? rs1_byp_data   :
                  i_dstage.select_pc ? {i_pc_d, 1'b0} :   // Link base for jal
                  i_dstage.rs1_en    ? i_gpr_rs1      : '0;

   assign o_rs2 = rs2_byp_en         ? rs2_byp_data   :
                  i_dstage.rs2_en    ? i_gpr_rs2      : i_immed;

   // Load/store operands never see the PC or the immediate
   assign lsu_rs1_src = rs1_byp_en ? rs1_byp_data : ({exu_pkg::XLEN{i_dstage.rs1_en}} & i_gpr_rs1);
   assign lsu_rs2_src = rs2_byp_en ? rs2_byp_data : ({exu_pkg::XLEN{i_dstage.rs2_en}} & i_gpr_rs2);

   assign o_lsu_rs1 = {exu_pkg::XLEN{i_dstage.qual_lsu}} & lsu_rs1_src;   // Quiet unless LSU op
   assign o_lsu_rs2 = {exu_pkg::XLEN{i_dstage.qual_lsu}} & lsu_rs2_src;

endmodule

//--- src/exu_alu.sv
/* X-stage ALU with branch resolution and final flush select
   Branch immediate and target offset are in halfwords, sign extended */
`timescale 1ns/10ps

module exu_alu (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_x_en,
   input  exu_pkg::alu_pkt_t        i_alu_pkt,
   input  bp_pkg::predict_pkt_t     i_predict_pkt,
   input  logic [exu_pkg::XLEN-1:0] i_rs1,
   input  logic [exu_pkg::XLEN-1:0] i_rs2,
   input  logic [exu_pkg::PC_W-1:0] i_pc_d,
   input  logic [11:0]              i_br_immed,
   input  logic                     i_flush_lower_r,
   input  logic [exu_pkg::PC_W-1:0] i_flush_path_r,
   output logic [exu_pkg::XLEN-1:0] o_result_x,
   output logic [exu_pkg::PC_W-1:0] o_pc_x,
   output logic                     o_flush_upper_x,
   output logic                     o_flush_final,
   output logic [exu_pkg::PC_W-1:0] o_flush_path_final,
   output logic [exu_pkg::PC_W-1:0] o_flush_path_x,
   output logic [exu_pkg::PC_W-1:0] o_npc_seq_x,
   output bp_pkg::predict_pkt_t     o_pp_x,
   output bp_pkg::predict_pkt_t     o_mp_pkt,
   output logic                     o_valid_x,
   output logic                     o_taken_x
);

   localparam int PC_W = exu_pkg::PC_W;
   localparam int TW   = bp_pkg::TOFFSET_W;

   exu_pkg::alu_pkt_t        ap_x;
   bp_pkg::predict_pkt_t     pp_x;
   bp_pkg::predict_pkt_t     pp_res;
   logic [exu_pkg::XLEN-1:0] a_x;
   logic [exu_pkg::XLEN-1:0] b_x;
   logic [PC_W-1:0]          pc_x;
   logic [11:0]              br_immed_x;
   logic [4:0]               shamt;
   logic                     eq;
   logic                     lt;
   logic                     ltu;
   logic                     taken;
   logic                     br_valid;
   logic                     mispredict;
   logic [PC_W-1:0]          npc_seq;
   logic [PC_W-1:0]          target;
   logic [PC_W-1:0]          pred_target;
   logic [PC_W-1:0]          redirect;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         ap_x <= '0;
      end else if (i_x_en) begin
         ap_x       <= i_alu_pkt;
         ap_x.valid <= i_alu_pkt.valid & ~i_flush_lower_r;   // Killed by lower flush
      end
   end

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         pp_x       <= i_predict_pkt;
         a_x        <= i_rs1;
         b_x        <= i_rs2;
         pc_x       <= i_pc_d;
         br_immed_x <= i_br_immed;
      end
   end

   assign shamt = b_x[4:0];
   assign eq    = (a_x == b_x);
   assign lt    = ($signed(a_x) < $signed(b_x));
   assign ltu   = (a_x < b_x);

   // Halfword units, so +2 for a 4-byte instruction
   assign npc_seq     = pc_x + (ap_x.pc4 ? PC_W'(2) : PC_W'(1));
   assign target      = pc_x + {{(PC_W-12){br_immed_x[11]}}, br_immed_x};
   assign pred_target = pc_x + {{(PC_W-TW){pp_x.toffset[TW-1]}}, pp_x.toffset};

   always_comb begin
      case (ap_x.op)
         exu_pkg::ALU_ADD:  o_result_x = a_x + b_x;
         exu_pkg::ALU_SUB:  o_result_x = a_x - b_x;
         exu_pkg::ALU_SLT:  o_result_x = {{(exu_pkg::XLEN-1){1'b0}}, lt};
         exu_pkg::ALU_SLTU: o_result_x = {{(exu_pkg::XLEN-1){1'b0}}, ltu};
         exu_pkg::ALU_AND:  o_result_x = a_x & b_x;
         exu_pkg::ALU_OR:   o_result_x = a_x | b_x;
         exu_pkg::ALU_XOR:  o_result_x = a_x ^ b_x;
         exu_pkg::ALU_SLL:  o_result_x = a_x << shamt;
         exu_pkg::ALU_SRL:  o_result_x = a_x >> shamt;
         exu_pkg::ALU_SRA:  o_result_x = $signed(a_x) >>> shamt;
         exu_pkg::ALU_JAL:  o_result_x = {npc_seq, 1'b0};      // Link address
         default:           o_result_x = '0;                   // Conditional branches
      endcase
   end

   always_comb begin
      case (ap_x.op)
         exu_pkg::ALU_BEQ:  taken = eq;
         exu_pkg::ALU_BNE:  taken = ~eq;
         exu_pkg::ALU_BLT:  taken = lt;
         exu_pkg::ALU_BGE:  taken = ~lt;
         exu_pkg::ALU_BLTU: taken = ltu;
         exu_pkg::ALU_BGEU: taken = ~ltu;
         exu_pkg::ALU_JAL:  taken = 1'b1;
         default:           taken = 1'b0;
      endcase
   end

   assign br_valid   = ap_x.valid & ap_x.branch;
   assign mispredict = br_valid & ((taken != pp_x.ataken) | (taken & (target != pred_target)));
   assign redirect   = taken ? target : npc_seq;

   always_comb begin
      pp_res         = pp_x;
      pp_res.valid   = pp_x.valid & ap_x.valid;
      pp_res.ataken  = taken;                                 // Actual direction
      pp_res.misp    = mispredict;
      pp_res.boffset = pc_x[0];                               // Address bit 1
   end

   assign o_flush_upper_x    = mispredict & ~i_flush_lower_r;  // Older flush wins
   assign o_flush_final      = o_flush_upper_x | i_flush_lower_r;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : redirect;
   assign o_flush_path_x     = redirect;
   assign o_npc_seq_x        = npc_seq;
   assign o_pc_x             = pc_x;
   assign o_pp_x             = pp_res;
   assign o_mp_pkt           = o_flush_upper_x ? pp_res : '0;
   assign o_valid_x          = pp_x.valid & ap_x.valid;       // Same qualifier as D history
   assign o_taken_x          = taken;

endmodule

//--- src/exu_ghr.sv
/* Global branch history, speculative at D and resolved at X
   GHR_W must be 2 or more */
`timescale 1ns/10ps

module exu_ghr #(
   parameter int GHR_W = 8
) (
   input  logic             clk,
   input  logic             i_reset,
   input  logic             i_x_en,
   input  logic             i_flush_lower_r,
   input  logic             i_flush_upper_x,
   input  logic             i_valid_d,
   input  logic             i_taken_d,
   input  logic             i_valid_x,
   input  logic             i_taken_x,
   output logic [GHR_W-1:0] o_ghr_x,
   output logic [GHR_W-1:0] o_mp_fghr
);

   logic [GHR_W-1:0] ghr_d;
   logic [GHR_W-1:0] ghr_x;

   // D copy follows predictions and falls back to X on a lower flush
   always_ff @(posedge clk) begin
      if (i_reset) begin
         ghr_d <= '0;
      end else if (i_flush_lower_r) begin
         ghr_d <= ghr_x;
      end else if (i_valid_d) begin
         ghr_d <= {ghr_d[GHR_W-2:0], i_taken_d};   // Predicted direction
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         ghr_x <= '0;
      end else if (i_x_en & i_valid_x) begin
         ghr_x <= {ghr_x[GHR_W-2:0], i_taken_x};   // Actual direction
      end
   end

   assign o_ghr_x   = ghr_x;
   assign o_mp_fghr = i_flush_upper_x ? ghr_d : ghr_x;

endmodule

//--- src/exu_retire.sv
/* R-stage branch report and next PC
   GHR_W must match the fghr field of the report */
`timescale 1ns/10ps

module exu_retire #(
   parameter int GHR_W = 8
) (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_r_en,
   input  bp_pkg::predict_pkt_t     i_pp_x,
   input  logic [GHR_W-1:0]         i_ghr_x,
   input  logic                     i_flush_upper_x,
   input  logic [exu_pkg::PC_W-1:0] i_flush_path_x,
   input  logic [exu_pkg::PC_W-1:0] i_npc_seq_x,
   output bp_pkg::br_report_t       o_br_report,
   output logic [exu_pkg::PC_W-1:0] o_npc_r
);

   bp_pkg::predict_pkt_t     pp_r;
   logic                     pred_correct_r;
   logic [GHR_W-1:0]         ghr_r;
   logic [exu_pkg::PC_W-1:0] flush_path_r;
   logic [exu_pkg::PC_W-1:0] npc_seq_r;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pp_r           <= '0;
         pred_correct_r <= 1'b0;
      end else if (i_r_en) begin
         pp_r           <= i_pp_x;
         pred_correct_r <= ~i_flush_upper_x;
      end
   end

   always_ff @(posedge clk) begin
      if (i_r_en) begin
         ghr_r        <= i_ghr_x;
         flush_path_r <= i_flush_path_x;
         npc_seq_r    <= i_npc_seq_x;
      end
   end

   assign o_br_report.valid  = pp_r.valid;
   assign o_br_report.mp     = pp_r.misp;
   assign o_br_report.way    = pp_r.way;
   assign o_br_report.middle = pp_r.pc4 ^ pp_r.boffset;
   assign o_br_report.hist   = {2{pp_r.valid}} & pp_r.hist;   // No counter update when idle
   assign o_br_report.fghr   = ghr_r;

   assign o_npc_r = pred_correct_r ? npc_seq_r : flush_path_r;

endmodule

//--- src/exu_top.sv
/* Execute unit top, single issue, no handshakes
   i_x_en and i_r_en advance X and R, a stage holds while its strobe is low */
`timescale 1ns/10ps

module exu_top (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_x_en,
   input  logic                     i_r_en,
   input  exu_pkg::dstage_t         i_dstage,
   input  exu_pkg::alu_pkt_t        i_alu_pkt,
   input  bp_pkg::predict_pkt_t     i_predict_pkt,
   input  logic [exu_pkg::XLEN-1:0] i_gpr_rs1,
   input  logic [exu_pkg::XLEN-1:0] i_gpr_rs2,
   input  logic [exu_pkg::XLEN-1:0] i_immed,
   input  logic [exu_pkg::XLEN-1:0] i_result_r,
   input  logic [exu_pkg::XLEN-1:0] i_lsu_result_m,
   input  logic [11:0]              i_br_immed,
   input  logic [exu_pkg::PC_W-1:0] i_pc_d,
   input  logic                     i_flush_lower_r,
   input  logic [exu_pkg::PC_W-1:0] i_flush_path_r,
   output logic [exu_pkg::XLEN-1:0] o_lsu_rs1,
   output logic [exu_pkg::XLEN-1:0] o_lsu_rs2,
   output logic [exu_pkg::XLEN-1:0] o_result_x,
   output logic [exu_pkg::PC_W-1:0] o_pc_x,
   output logic                     o_flush_final,
   output logic [exu_pkg::PC_W-1:0] o_flush_path_final,
   output bp_pkg::predict_pkt_t     o_mp_pkt,
   output logic [bp_pkg::GHR_W-1:0] o_mp_fghr,
   output bp_pkg::br_report_t       o_br_report,
   output logic [exu_pkg::PC_W-1:0] o_npc_r
);

   localparam int GHR_W = bp_pkg::GHR_W;

   logic [exu_pkg::XLEN-1:0] rs1_d;
   logic [exu_pkg::XLEN-1:0] rs2_d;
   logic                     flush_upper_x;
   logic [exu_pkg::PC_W-1:0] flush_path_x;
   logic [exu_pkg::PC_W-1:0] npc_seq_x;
   bp_pkg::predict_pkt_t     pp_x;
   logic                     valid_d;
   logic                     taken_d;
   logic                     valid_x;
   logic                     taken_x;
   logic [GHR_W-1:0]         ghr_x;

   assign valid_d = i_predict_pkt.valid  & i_alu_pkt.valid;    // Predicted branch at D
   assign taken_d = i_predict_pkt.ataken & i_alu_pkt.valid;

   exu_operand_mux u_operand_mux (
      .i_dstage       (i_dstage),
      .i_gpr_rs1      (i_gpr_rs1),
      .i_gpr_rs2      (i_gpr_rs2),
      .i_immed        (i_immed),
      .i_pc_d         (i_pc_d),
      .i_result_r     (i_result_r),
      .i_lsu_result_m (i_lsu_result_m),
      .i_result_x     (o_result_x),                          // X bypass
      .o_rs1          (rs1_d),
      .o_rs2          (rs2_d),
      .o_lsu_rs1      (o_lsu_rs1),
      .o_lsu_rs2      (o_lsu_rs2)
   );

   exu_alu u_alu (
      .clk                (clk),
      .i_reset            (i_reset),
      .i_x_en             (i_x_en),
      .i_alu_pkt          (i_alu_pkt),
      .i_predict_pkt      (i_predict_pkt),
      .i_rs1              (rs1_d),
      .i_rs2              (rs2_d),
      .i_pc_d             (i_pc_d),
      .i_br_immed         (i_br_immed),
      .i_flush_lower_r    (i_flush_lower_r),
      .i_flush_path_r     (i_flush_path_r),
      .o_result_x         (o_result_x),
      .o_pc_x             (o_pc_x),
      .o_flush_upper_x    (flush_upper_x),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final),
      .o_flush_path_x     (flush_path_x),
      .o_npc_seq_x        (npc_seq_x),
      .o_pp_x             (pp_x),
      .o_mp_pkt           (o_mp_pkt),
      .o_valid_x          (valid_x),
      .o_taken_x          (taken_x)
   );

   exu_ghr #(.GHR_W(GHR_W)) u_ghr (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_x_en          (i_x_en),
      .i_flush_lower_r (i_flush_lower_r),
      .i_flush_upper_x (flush_upper_x),
      .i_valid_d       (valid_d),
      .i_taken_d       (taken_d),
      .i_valid_x       (valid_x),
      .i_taken_x       (taken_x),
      .o_ghr_x         (ghr_x),
      .o_mp_fghr       (o_mp_fghr)
   );

   exu_retire #(.GHR_W(GHR_W)) u_retire (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_r_en          (i_r_en),
      .i_pp_x          (pp_x),
      .i_ghr_x         (ghr_x),
      .i_flush_upper_x (flush_upper_x),
      .i_flush_path_x  (flush_path_x),
      .i_npc_seq_x     (npc_seq_x),
      .o_br_report     (o_br_report),
      .o_npc_r         (o_npc_r)
   );

endmodule

//--- verif/exu_tb.sv
/* Directed testbench for exu_top, checks against a model in the testbench
   PCs are halfword addresses (bits 31:1) as on the DUT ports */
`timescale 1ns/10ps

module exu_tb;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 6;
   localparam int GW         = bp_pkg::GHR_W;

   logic                 clk = 1'b0;
   logic                 i_reset;
   logic                 i_x_en;
   logic                 i_r_en;
   logic                 i_flush_lower_r;
   exu_pkg::dstage_t     i_dstage;
   exu_pkg::alu_pkt_t    i_alu_pkt;
   bp_pkg::predict_pkt_t i_predict_pkt;
   bp_pkg::predict_pkt_t o_mp_pkt;
   bp_pkg::br_report_t   o_br_report;
   logic [31:0]          i_gpr_rs1;
   logic [31:0]          i_gpr_rs2;
   logic [31:0]          i_immed;
   logic [31:0]          i_result_r;
   logic [31:0]          i_lsu_result_m;
   logic [31:0]          o_lsu_rs1;
   logic [31:0]          o_lsu_rs2;
   logic [31:0]          o_result_x;
   logic [11:0]          i_br_immed;
   logic [30:0]          i_pc_d;
   logic [30:0]          i_flush_path_r;
   logic [30:0]          o_pc_x;
   logic [30:0]          o_flush_path_final;
   logic [30:0]          o_npc_r;
   logic                 o_flush_final;
   logic [GW-1:0]        o_mp_fghr;

   int                   errors = 0;
   int                   checks = 0;
   logic [31:0]          seed = 32'h8c7e;
   logic [GW-1:0]        ghr_d_m = '0;                 // Model of the D history
   logic [GW-1:0]        ghr_x_m = '0;                 // Model of the X history
   logic                 x_valid_m = 1'b0;
   logic                 x_taken_m = 1'b0;
   logic                 d_taken_m = 1'b0;             // Actual direction of the D instruction

   exu_top u_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * 200);
      $display("sim failed");
      $finish;
   end

   function automatic logic [31:0] lcg();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   function automatic logic model_taken(input exu_pkg::alu_op_e op, input logic [31:0] a, b);
      case (op)
         exu_pkg::ALU_BEQ:  return a == b;
         exu_pkg::ALU_BNE:  return a != b;
         exu_pkg::ALU_BLT:  return $signed(a) < $signed(b);
         exu_pkg::ALU_BGE:  return $signed(a) >= $signed(b);
         exu_pkg::ALU_BLTU: return a < b;
         exu_pkg::ALU_BGEU: return a >= b;
         exu_pkg::ALU_JAL:  return 1'b1;
         default:           return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] model_result(input exu_pkg::alu_op_e op,
                                                input logic [31:0] a, b);
      case (op)
         exu_pkg::ALU_ADD:  return a + b;
         exu_pkg::ALU_SUB:  return a + ~b + 32'd1;     // Two's complement
         exu_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
         exu_pkg::ALU_SLTU: return {31'd0, a < b};
         exu_pkg::ALU_AND:  return a & b;
         exu_pkg::ALU_OR:   return a | b;
         exu_pkg::ALU_XOR:  return a ^ b;
         exu_pkg::ALU_SLL:  return a << b[4:0];
         exu_pkg::ALU_SRL:  return a >> b[4:0];
         exu_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
         default:           return 32'd0;
      endcase
   endfunction

   // One clock edge, history model follows the inputs seen at the edge
   task automatic tick();
      if (i_flush_lower_r)
         ghr_d_m = ghr_x_m;
      else if (i_predict_pkt.valid && i_alu_pkt.valid)
         ghr_d_m = {ghr_d_m[GW-2:0], i_predict_pkt.ataken};
      if (i_x_en) begin
         if (x_valid_m)
            ghr_x_m = {ghr_x_m[GW-2:0], x_taken_m};
         x_valid_m = i_predict_pkt.valid && i_alu_pkt.valid && !i_flush_lower_r;
         x_taken_m = d_taken_m;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic exec_x();
      i_x_en = 1'b1;
      tick();
      i_x_en          = 1'b0;
      i_alu_pkt.valid = 1'b0;                          // No further D history shifts
   endtask

   task automatic exec_r();
      i_r_en = 1'b1;
      tick();
      i_r_en = 1'b0;
   endtask

   task automatic drive_alu(input exu_pkg::alu_op_e op, input logic [31:0] a, b,
                            input logic use_imm);
      i_dstage        = '0;
      i_dstage.rs1_en = 1'b1;
      i_dstage.rs2_en = !use_imm;
      i_gpr_rs1       = a;
      i_gpr_rs2       = use_imm ? lcg() : b;           // Unused source carries noise
      i_immed         = use_imm ? b : lcg();
      i_alu_pkt       = '{1'b1, op, 1'b0, 1'b1};
      i_predict_pkt   = '0;
      d_taken_m       = 1'b0;
   endtask

   task automatic drive_branch(input exu_pkg::alu_op_e op, input logic [31:0] a, b,
                               input logic [30:0] pc, input logic pc4, input logic [11:0] imm,
                               input logic pred_taken, input logic [11:0] toff);
      i_dstage           = '0;
      i_dstage.rs1_en    = 1'b1;
      i_dstage.rs2_en    = 1'b1;
      i_dstage.select_pc = (op == exu_pkg::ALU_JAL);
      i_gpr_rs1          = a;
      i_gpr_rs2          = b;
      i_pc_d             = pc;
      i_br_immed         = imm;
      i_alu_pkt          = '{1'b1, op, 1'b1, pc4};
      i_predict_pkt         = '0;
      i_predict_pkt.valid   = 1'b1;
      i_predict_pkt.way     = pc[1];
      i_predict_pkt.ataken  = pred_taken;
      i_predict_pkt.pc4     = pc4;
      i_predict_pkt.hist    = pc[3:2];
      i_predict_pkt.toffset = toff;
      d_taken_m             = model_taken(op, a, b);
   endtask

   // Branch through X and R with all flush, packet and report checks
   task automatic run_branch(input exu_pkg::alu_op_e op, input logic [31:0] a, b,
                             input logic [30:0] pc, input logic pc4, input logic [11:0] imm,
                             input logic pred_taken, input logic [11:0] toff);
      logic                 taken;
      logic                 misp;
      logic [30:0]          npc;
      logic [30:0]          redirect;
      bp_pkg::predict_pkt_t mp_exp;
      bp_pkg::br_report_t   rep;
      taken    = model_taken(op, a, b);
      npc      = pc + (pc4 ? 31'd2 : 31'd1);
      redirect = taken ? pc + {{19{imm[11]}}, imm} : npc;
      misp     = (taken != pred_taken) || (taken && (toff != imm));
      mp_exp   = '{1'b1, pc[1], 1'b1, taken, pc4, pc[0], 1'b0, 1'b0, 1'b0, pc[3:2], toff};
      drive_branch(op, a, b, pc, pc4, imm, pred_taken, toff);
      exec_x();
      check("o_result_x", o_result_x,
            (op == exu_pkg::ALU_JAL) ? {pc, 1'b0} + (pc4 ? 32'd4 : 32'd2) : 32'd0);
      check("o_pc_x", 32'(o_pc_x), 32'(pc));
      check("o_flush_final", 32'(o_flush_final), 32'(misp));
      check("o_mp_fghr", 32'(o_mp_fghr), 32'(misp ? ghr_d_m : ghr_x_m));
      if (misp) begin
         check("o_flush_path_final", 32'(o_flush_path_final), 32'(redirect));
         check("o_mp_pkt", 32'(o_mp_pkt), 32'(mp_exp));
      end else begin
         check("o_mp_pkt", 32'(o_mp_pkt), 32'd0);
      end
      exec_r();
      rep = '{1'b1, misp, pc[1], pc4 ^ pc[0], pc[3:2], ghr_x_m};
      check("o_br_report", 32'(o_br_report), 32'(rep));
      check("o_npc_r", 32'(o_npc_r), 32'(misp ? redirect : npc));
   endtask

   task automatic test_alu();
      logic [31:0] a;
      logic [31:0] b;
      for (int k = 0; k < 10; k++) begin
         for (int m = 0; m < 2; m++) begin
            a = lcg();
            b = lcg();
            drive_alu(exu_pkg::alu_op_e'(5'(k)), a, b, m == 1);
            exec_x();
            check("o_result_x", o_result_x, model_result(exu_pkg::alu_op_e'(5'(k)), a, b));
         end
      end
   endtask

   task automatic test_bypass();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] byp;
      logic [31:0] exp_a;
      logic [31:0] exp_b;
      logic [31:0] last_x;
      logic        qual;
      a = lcg();
      b = lcg();
      drive_alu(exu_pkg::ALU_ADD, a, b, 1'b0);
      exec_x();
      last_x = a + b;
      for (int k = 0; k < 6; k++) begin                // r, m and x sources on rs1 then rs2
         a              = lcg();
         b              = lcg();
         i_result_r     = lcg();
         i_lsu_result_m = lcg();
         byp  = (k / 2 == 0) ? i_result_r : (k / 2 == 1) ? i_lsu_result_m : last_x;
         qual = ((k / 2 + k) % 2) == 1;
         drive_alu(exu_pkg::ALU_ADD, a, b, 1'b0);
         i_dstage.qual_lsu = qual;
         if (k % 2 == 0)
            i_dstage.rs1_byp = exu_pkg::bypass_sel_t'(3'b100 >> (k / 2));
         else
            i_dstage.rs2_byp = exu_pkg::bypass_sel_t'(3'b100 >> (k / 2));
         exp_a = (k % 2 == 0) ? byp : a;
         exp_b = (k % 2 == 1) ? byp : b;
         #1;
         check("o_lsu_rs1", o_lsu_rs1, qual ? exp_a : 32'd0);
         check("o_lsu_rs2", o_lsu_rs2, qual ? exp_b : 32'd0);
         exec_x();
         last_x = exp_a + exp_b;                       // Chains into the next X bypass
         check("o_result_x", o_result_x, last_x);
      end
   endtask

   task automatic test_branch_ok();
      exu_pkg::alu_op_e op;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [11:0]      imm;
      for (int k = 0; k < 8; k++) begin
         op  = (k < 7) ? exu_pkg::alu_op_e'(5'(10 + k)) : exu_pkg::ALU_JAL;
         a   = lcg();
         b   = (k % 2 == 0) ? a : lcg();
         imm = 12'(lcg());
         run_branch(op, a, b, 31'(lcg()), k != 3 && k != 7, imm, model_taken(op, a, b), imm);
      end
   endtask

   task automatic test_mispredict();
      logic [31:0] a;
      logic [11:0] imm;
      a   = lcg();
      imm = 12'(lcg());
      run_branch(exu_pkg::ALU_BEQ, a, a, 31'(lcg()), 1'b1, imm, 1'b0, imm);
      run_branch(exu_pkg::ALU_BEQ, a, ~a, 31'(lcg()), 1'b1, imm, 1'b1, imm);
      run_branch(exu_pkg::ALU_BNE, a, ~a, 31'(lcg()), 1'b0, imm, 1'b1, imm ^ 12'h010);
      run_branch(exu_pkg::ALU_JAL, a, a, 31'(lcg()), 1'b1, imm, 1'b1, imm + 12'd4);
   endtask

   task automatic test_lower_flush();
      logic [31:0] a;
      logic [30:0] path;
      a    = lcg();
      path = 31'(lcg());
      drive_branch(exu_pkg::ALU_BNE, a, a, 31'(lcg()), 1'b1, 12'h040, 1'b1, 12'h040);
      exec_x();                                        // X now holds a mispredict
      i_flush_lower_r = 1'b1;
      i_flush_path_r  = path;
      #1;
      check("o_flush_final", 32'(o_flush_final), 32'd1);
      check("o_flush_path_final", 32'(o_flush_path_final), 32'(path));
      check("o_mp_pkt", 32'(o_mp_pkt), 32'd0);
      tick();                                          // D history restored from X
      i_flush_lower_r = 1'b0;
   endtask

   task automatic test_history();
      logic [31:0] a;
      logic [31:0] b;
      logic [11:0] imm;
      imm = 12'(lcg());
      run_branch(exu_pkg::ALU_BLTU, 32'd0, 32'd1, 31'(lcg()), 1'b1, imm, 1'b0, imm);
      for (int k = 0; k < 5; k++) begin
         a = lcg();
         b = lcg();
         run_branch(exu_pkg::ALU_BGE, a, b, 31'(lcg()), 1'b1, imm,
                    model_taken(exu_pkg::ALU_BGE, a, b), imm);
      end
      run_branch(exu_pkg::ALU_BEQ, 32'd5, 32'd5, 31'(lcg()), 1'b1, imm, 1'b0, imm);
   endtask

   initial begin
      i_reset         = 1'b1;
      i_x_en          = 1'b0;
      i_r_en          = 1'b0;
      i_flush_lower_r = 1'b0;
      i_flush_path_r  = '0;
      i_dstage        = '0;
      i_alu_pkt       = '0;
      i_predict_pkt   = '0;
      i_gpr_rs1       = '0;
      i_gpr_rs2       = '0;
      i_immed         = '0;
      i_result_r      = '0;
      i_lsu_result_m  = '0;
      i_br_immed      = '0;
      i_pc_d          = '0;
      repeat (5) @(posedge clk);
      #1;
      i_reset = 1'b0;
      check("o_flush_final", 32'(o_flush_final), 32'd0);
      check("o_mp_pkt", 32'(o_mp_pkt), 32'd0);
      check("o_br_report.valid", 32'(o_br_report.valid), 32'd0);
      check("o_mp_fghr", 32'(o_mp_fghr), 32'd0);
      test_alu();
      test_bypass();
      test_branch_ok();
      test_mispredict();
      test_lower_flush();
      test_history();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- sim.f
src/exu_pkg.sv
src/bp_pkg.sv
src/exu_operand_mux.sv
src/exu_alu.sv
src/exu_ghr.sv
src/exu_retire.sv
src/exu_top.sv
verif/exu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module exu_tb -f sim.f -o exu_sim
./obj_dir/exu_sim | tee sim.log

if grep -q "^sim passed$" sim.log; then
   echo "Result: PASS"
   exit 0
else
   echo "Result: FAIL"
   exit 1
fi
